//--- include/vec_params.svh
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

////////////////////////////////////////////////////////////
// Vector slice geometry
////////////////////////////////////////////////////////////

// Lanes per vector and bits per lane element
`define VEC_LANES   16
`define VEC_ELEM_W  8

// Vector register file size
`define VEC_REGS    8

// Index width for VEC_REGS registers
`define VEC_REG_AW  3

`endif

//--- list.f
+incdir+include
+incdir+sim
verilog/vec_pkg.sv
verilog/vector_lane.sv
verilog/vec_issue.sv
verilog/vec_writeback.sv
verilog/vec_unit.sv
sim/vec_unit_tb.sv

//--- sim/vec_ref_model.svh
`ifndef VEC_REF_MODEL_SVH
`define VEC_REF_MODEL_SVH

// Register contents as the testbench predicts them
vec_data_t shadow [`VEC_REGS];

// Copy taken before a producer, for reads issued too early to see it
vec_data_t stale_regs [`VEC_REGS];

logic [31:0] lfsr_state = 32'hbead;

////////////////////////////////////////////////////////////
// Random bits
////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

// n fresh bits, one step each
function automatic logic [31:0] lfsr_take(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_step()};
	end
	return v;
endfunction

////////////////////////////////////////////////////////////
// Element reference
////////////////////////////////////////////////////////////

function automatic lane_rsp_t ref_elem(vec_op_e op, elem_t a, elem_t b);
	lane_rsp_t r;
	int        t;
	t     = 0;
	r.sat = 1'b0;
	case (op)
		OP_ADD:  t = int'(a) + int'(b);
		OP_SUB:  t = int'(a) - int'(b) + 256;
		OP_ADDS: begin
			t = int'(a) + int'(b);
			if (t > 255) begin
				t     = 255;
				r.sat = 1'b1;
			end
		end
		OP_AND:  t = a & b;
		OP_OR:   t = a | b;
		OP_XOR:  t = a ^ b;
		// Shift by the low three bits of b
		OP_SHL:  t = int'(a) * (2 ** (b % 8));
		OP_SHR:  t = int'(a) / (2 ** (b % 8));
		OP_MIN:  t = (a <= b) ? a : b;
		OP_MAX:  t = (a >= b) ? a : b;
		OP_MOV:  t = b;
		default: t = 0;
	endcase
	r.data = elem_t'(t % 256);
	return r;
endfunction

// Whole expected result, built lane by lane
function automatic vec_wb_t expect_wb(vec_instr_t in, logic stale);
	vec_wb_t   w;
	vec_data_t va;
	vec_data_t vb;
	elem_t     b;
	lane_rsp_t r;
	va      = stale ? stale_regs[in.vs1] : shadow[in.vs1];
	vb      = stale ? stale_regs[in.vs2] : shadow[in.vs2];
	w.valid = 1'b1;
	w.vd    = in.vd;
	for (int i = 0; i < `VEC_LANES; i++) begin
		b = in.use_scalar ? in.scalar : vb[i*`VEC_ELEM_W +: `VEC_ELEM_W];
		r = ref_elem(in.op, va[i*`VEC_ELEM_W +: `VEC_ELEM_W], b);
		w.data[i*`VEC_ELEM_W +: `VEC_ELEM_W] = r.data;
		w.sat[i] = r.sat;
	end
	return w;
endfunction

`endif

//--- sim/vec_unit_tb.sv
`include "vec_params.svh"

module vec_unit_tb import vec_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;

	logic       clk;
	logic       arst_n;
	vec_instr_t instr;
	vec_wb_t    result;

	// Expected results and the cycle each one is due on
	vec_wb_t exp_q [$];
	int      due_q [$];
	int      cycle = 0;

	`include "vec_ref_model.svh"

	vec_unit i_vec_unit (
		.clk    (clk),
		.arst_n (arst_n),
		.instr  (instr),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////////////////////////

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_error(string msg);
		abort_run($sformatf("** Error at time %0t: %s", $time, msg));
	endtask

	task automatic check_wb(vec_wb_t got, vec_wb_t exp);
		if (got !== exp) begin
			report_error($sformatf("got valid %b v%0d data %h sat %h, expected v%0d data %h sat %h",
				got.valid, got.vd, got.data, got.sat, exp.vd, exp.data, exp.sat));
		end
	endtask

	task automatic check_idle(logic got_valid, logic exp_valid);
		if (got_valid !== exp_valid) begin
			report_error($sformatf("result valid %b, expected %b", got_valid, exp_valid));
		end
	endtask

	// Cycle count moves on the falling edge so it is stable at the rising edge
	always @(negedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			abort_run("Timeout: the tests did not finish within the cycle limit");
		end
	end

	// Result monitor
	always @(posedge clk) begin
		if (due_q.size() > 0 && due_q[0] == cycle) begin
			check_wb(result, exp_q[0]);
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
		end else begin
			check_idle(result.valid, 1'b0);
		end
	end

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	task automatic issue_instr(vec_op_e op, reg_idx_t vd, reg_idx_t vs1, reg_idx_t vs2,
		logic use_scalar, elem_t scalar, logic stale);
		vec_instr_t in;
		vec_wb_t    exp;
		in.valid      = 1'b1;
		in.op         = op;
		in.vd         = vd;
		in.vs1        = vs1;
		in.vs2        = vs2;
		in.use_scalar = use_scalar;
		in.scalar     = scalar;
		exp           = expect_wb(in, stale);
		shadow[vd]    = exp.data;
		@(posedge clk);
		instr <= in;
		// Sampled at the next edge, result three edges after that
		exp_q.push_back(exp);
		due_q.push_back(cycle + 4);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		instr <= '0;
	endtask

	task automatic drain_pipe();
		idle_cycle();
		while (due_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic after_reset();
		repeat (5) idle_cycle();
		issue_instr(OP_OR, 3'd0, 3'd0, 3'd1, 1'b0, 8'h00, 1'b0);
		drain_pipe();
	endtask

	task automatic splat_and_latency();
		elem_t s;
		for (int r = 0; r < `VEC_REGS; r++) begin
			s = elem_t'(lfsr_take(8));
			issue_instr(OP_MOV, reg_idx_t'(r), reg_idx_t'(r), reg_idx_t'(r), 1'b1, s, 1'b0);
		end
		drain_pipe();
		for (int r = 0; r < `VEC_REGS; r++) begin
			issue_instr(OP_MOV, reg_idx_t'(r), reg_idx_t'(r), reg_idx_t'(r), 1'b0, 8'h00, 1'b0);
		end
		drain_pipe();
	endtask

	task automatic element_ops();
		elem_t    s;
		reg_idx_t vd;
		reg_idx_t vs1;
		reg_idx_t vs2;
		// Splat then XOR, three cycles apart
		for (int r = 0; r < `VEC_REGS; r++) begin
			s = elem_t'(lfsr_take(8));
			issue_instr(OP_MOV, reg_idx_t'(r), reg_idx_t'(r), reg_idx_t'(r), 1'b1, s, 1'b0);
			idle_cycle();
			idle_cycle();
			s = elem_t'(lfsr_take(8));
			issue_instr(OP_XOR, reg_idx_t'(r), reg_idx_t'(r), reg_idx_t'(r), 1'b1, s, 1'b0);
		end
		drain_pipe();
		repeat (3) begin
			for (int o = 0; o <= 10; o++) begin
				for (int m = 0; m < 2; m++) begin
					vd  = reg_idx_t'(lfsr_take(3));
					vs1 = reg_idx_t'(lfsr_take(3));
					vs2 = reg_idx_t'(lfsr_take(3));
					s   = elem_t'(lfsr_take(8));
					issue_instr(vec_op_e'(o), vd, vs1, vs2, m[0], s, 1'b0);
					drain_pipe();
				end
			end
		end
	endtask

	task automatic saturation_flags();
		issue_instr(OP_MOV, 3'd1, 3'd1, 3'd1, 1'b1, 8'd200, 1'b0);
		issue_instr(OP_MOV, 3'd2, 3'd2, 3'd2, 1'b1, 8'd100, 1'b0);
		issue_instr(OP_MOV, 3'd3, 3'd3, 3'd3, 1'b1, 8'd20, 1'b0);
		drain_pipe();
		issue_instr(OP_ADDS, 3'd4, 3'd1, 3'd2, 1'b0, 8'd0, 1'b0);
		issue_instr(OP_ADDS, 3'd5, 3'd1, 3'd3, 1'b0, 8'd0, 1'b0);
		// Exactly 255 does not saturate, 256 does
		issue_instr(OP_ADDS, 3'd6, 3'd1, 3'd1, 1'b1, 8'd55, 1'b0);
		issue_instr(OP_ADDS, 3'd7, 3'd1, 3'd1, 1'b1, 8'd56, 1'b0);
		issue_instr(OP_ADD, 3'd6, 3'd1, 3'd2, 1'b0, 8'd0, 1'b0);
		drain_pipe();
	endtask

	task automatic back_to_back();
		logic [11:0] pattern;
		vec_op_e     op;
		reg_idx_t    vs1;
		reg_idx_t    vs2;
		elem_t       s;
		pattern = 12'b1110_0101_1011;
		// All writes go to v7, which no instruction here reads
		for (int i = 0; i < 12; i++) begin
			if (pattern[i]) begin
				op  = vec_op_e'(lfsr_take(4) % 11);
				vs1 = reg_idx_t'(lfsr_take(3) % 7);
				vs2 = reg_idx_t'(lfsr_take(3) % 7);
				s   = elem_t'(lfsr_take(8));
				issue_instr(op, 3'd7, vs1, vs2, lfsr_step(), s, 1'b0);
			end else begin
				idle_cycle();
			end
		end
		drain_pipe();
	endtask

	task automatic writeback_spacing();
		elem_t s;
		for (int r = 0; r < `VEC_REGS; r++) begin
			stale_regs[r] = shadow[r];
		end
		// Nonzero add so the new v2 differs from the old one
		s = elem_t'(lfsr_take(8)) | 8'h01;
		issue_instr(OP_ADD, 3'd2, 3'd2, 3'd2, 1'b1, s, 1'b0);
		issue_instr(OP_MOV, 3'd5, 3'd0, 3'd2, 1'b0, 8'h00, 1'b1);
		issue_instr(OP_MOV, 3'd6, 3'd0, 3'd2, 1'b0, 8'h00, 1'b1);
		issue_instr(OP_MOV, 3'd7, 3'd0, 3'd2, 1'b0, 8'h00, 1'b0);
		drain_pipe();
	endtask

	initial begin
		instr  = '0;
		arst_n = 1'b0;
		for (int r = 0; r < `VEC_REGS; r++) begin
			shadow[r] = '0;
		end
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		after_reset();
		splat_and_latency();
		element_ops();
		saturation_flags();
		back_to_back();
		writeback_spacing();
		$display("All checks passed");
		$finish;
	end

endmodule

//--- verilog/vec_issue.sv
`include "vec_params.svh"

module vec_issue import vec_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  vec_instr_t instr,
	input  vec_wb_t    wb,
	output lane_req_t  lane_req [`VEC_LANES],
	output vec_ctrl_t  ctrl
);

	// Register file storage
	vec_data_t regs [`VEC_REGS];

	// Raw register reads
	vec_data_t rd_a;
	vec_data_t rd_b;

	// Reads after write-through from the writeback port
	vec_data_t src_a;
	vec_data_t src_b;

	// Second operand after scalar broadcast
	vec_data_t opnd_b;

	// Per-lane requests before the pipeline register
	lane_req_t req_d [`VEC_LANES];

	////////////////////////////////////////////////////////////
	// Vector register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `VEC_REGS; r++) begin
				regs[r] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.vd] <= wb.data;
		end
	end

	assign rd_a = regs[instr.vs1];
	assign rd_b = regs[instr.vs2];

	// Write-through so an instruction issued in the write cycle
	// already sees the result being written
	assign src_a = (wb.valid && (wb.vd == instr.vs1)) ? wb.data : rd_a;
	assign src_b = (wb.valid && (wb.vd == instr.vs2)) ? wb.data : rd_b;

	////////////////////////////////////////////////////////////
	// Operand select and lane slicing
	////////////////////////////////////////////////////////////

	// Scalar copied into every element
	assign opnd_b = instr.use_scalar ? {`VEC_LANES{instr.scalar}} : src_b;

	always_comb begin
		for (int i = 0; i < `VEC_LANES; i++) begin
			req_d[i].op = instr.op;
			req_d[i].a  = src_a[i*`VEC_ELEM_W +: `VEC_ELEM_W];
			req_d[i].b  = opnd_b[i*`VEC_ELEM_W +: `VEC_ELEM_W];
		end
	end

	////////////////////////////////////////////////////////////
	// Issue pipeline register
	////////////////////////////////////////////////////////////

	// Lane requests, cleared so the lanes start from known operands
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `VEC_LANES; i++) begin
				lane_req[i] <= '0;
			end
		end else begin
			lane_req <= req_d;
		end
	end

	// Valid and destination for the writeback stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
		end else begin
			ctrl.valid <= instr.valid;
			ctrl.vd    <= instr.vd;
		end
	end

endmodule

//--- verilog/vec_pkg.sv
`include "vec_params.svh"

package vec_pkg;

	////////////////////////////////////////////////////////////
	// Basic data types
	////////////////////////////////////////////////////////////

	// One lane element
	typedef logic [`VEC_ELEM_W-1:0] elem_t;

	// Full vector register, lane 0 in the low bits
	typedef logic [`VEC_LANES*`VEC_ELEM_W-1:0] vec_data_t;

	// Vector register index
	typedef logic [`VEC_REG_AW-1:0] reg_idx_t;

	// Element operations
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_ADDS = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,
		OP_SHR  = 4'd7,
		OP_MIN  = 4'd8,
		OP_MAX  = 4'd9,
		OP_MOV  = 4'd10
	} vec_op_e;

	////////////////////////////////////////////////////////////
	// Stage to stage structs
	////////////////////////////////////////////////////////////

	// Incoming instruction
	typedef struct packed {
		logic     valid;
		vec_op_e  op;
		reg_idx_t vd;
		reg_idx_t vs1;
		reg_idx_t vs2;
		// Second source replaced by scalar on every lane
		logic     use_scalar;
		elem_t    scalar;
	} vec_instr_t;

	// Work for one lane
	typedef struct packed {
		vec_op_e op;
		elem_t   a;
		elem_t   b;
	} lane_req_t;

	// Result of one lane
	typedef struct packed {
		elem_t data;
		logic  sat;
	} lane_rsp_t;

	// Control travelling beside the lanes
	typedef struct packed {
		logic     valid;
		reg_idx_t vd;
	} vec_ctrl_t;

	// Completed instruction, bit i of sat belongs to lane i
	typedef struct packed {
		logic                  valid;
		reg_idx_t              vd;
		vec_data_t             data;
		logic [`VEC_LANES-1:0] sat;
	} vec_wb_t;

endpackage

//--- verilog/vec_unit.sv
`include "vec_params.svh"

module vec_unit import vec_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  vec_instr_t instr,
	output vec_wb_t    result
);

	// Issue to lanes
	lane_req_t lane_req [`VEC_LANES];

	// Lanes to writeback
	lane_rsp_t lane_rsp [`VEC_LANES];

	// Issue to writeback
	vec_ctrl_t ctrl;

	////////////////////////////////////////////////////////////
	// Issue with register file
	////////////////////////////////////////////////////////////

	// Result doubles as the register write port
	vec_issue i_vec_issue (
		.clk      (clk),
		.arst_n   (arst_n),
		.instr    (instr),
		.wb       (result),
		.lane_req (lane_req),
		.ctrl     (ctrl)
	);

	////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////

	generate
		for (genvar i = 0; i < `VEC_LANES; i++) begin : g_lane
			vector_lane i_vector_lane (
				.clk    (clk),
				.arst_n (arst_n),
				.req    (lane_req[i]),
				.rsp    (lane_rsp[i])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////

	vec_writeback i_vec_writeback (
		.clk      (clk),
		.arst_n   (arst_n),
		.ctrl     (ctrl),
		.lane_rsp (lane_rsp),
		.wb       (result)
	);

endmodule

//--- verilog/vec_writeback.sv
`include "vec_params.svh"

module vec_writeback import vec_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  vec_ctrl_t ctrl,
	input  lane_rsp_t lane_rsp [`VEC_LANES],
	output vec_wb_t   wb
);

	// Control delayed to line up with the lane registers
	vec_ctrl_t ctrl_q;

	// Packed lane results
	vec_data_t             data_d;
	logic [`VEC_LANES-1:0] sat_d;

	// Output register fields
	logic                  wb_valid_q;
	reg_idx_t              wb_vd_q;
	vec_data_t             wb_data_q;
	logic [`VEC_LANES-1:0] wb_sat_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q <= ctrl;
		end
	end

	////////////////////////////////////////////////////////////
	// Pack lanes, lane 0 lowest
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `VEC_LANES; i++) begin
			data_d[i*`VEC_ELEM_W +: `VEC_ELEM_W] = lane_rsp[i].data;
			sat_d[i]                             = lane_rsp[i].sat;
		end
	end

	// Control part of the result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid_q <= 1'b0;
			wb_vd_q    <= '0;
		end else begin
			wb_valid_q <= ctrl_q.valid;
			wb_vd_q    <= ctrl_q.vd;
		end
	end

	// Data part, only meaningful with valid
	always_ff @(posedge clk) begin
		wb_data_q <= data_d;
		wb_sat_q  <= sat_d;
	end

	assign wb = '{valid: wb_valid_q, vd: wb_vd_q, data: wb_data_q, sat: wb_sat_q};

endmodule

//--- verilog/vector_lane.sv
`include "vec_params.svh"

module vector_lane import vec_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  lane_req_t req,
	output lane_rsp_t rsp
);

	// Shift amount bits taken from b
	localparam int SHAMT_W = $clog2(`VEC_ELEM_W);

	// Sum with carry out for the saturating add
	logic [`VEC_ELEM_W:0] sum;

	logic [SHAMT_W-1:0] shamt;

	// Combinational result
	elem_t res;
	logic  sat;

	assign sum   = {1'b0, req.a} + {1'b0, req.b};
	assign shamt = req.b[SHAMT_W-1:0];

	////////////////////////////////////////////////////////////
	// Element ALU
	////////////////////////////////////////////////////////////

	always_comb begin
		res = '0;
		sat = 1'b0;
		case (req.op)
			// Wraps modulo 256
			OP_ADD:  res = sum[`VEC_ELEM_W-1:0];
			OP_SUB:  res = req.a - req.b;
			OP_ADDS: begin
				// Clamp at all ones on carry out
				sat = sum[`VEC_ELEM_W];
				res = sum[`VEC_ELEM_W] ? '1 : sum[`VEC_ELEM_W-1:0];
			end
			OP_AND:  res = req.a & req.b;
			OP_OR:   res = req.a | req.b;
			OP_XOR:  res = req.a ^ req.b;
			OP_SHL:  res = req.a << shamt;
			OP_SHR:  res = req.a >> shamt;
			// Unsigned compare
			OP_MIN:  res = (req.a < req.b) ? req.a : req.b;
			OP_MAX:  res = (req.a > req.b) ? req.a : req.b;
			OP_MOV:  res = req.b;
			default: res = '0;
		endcase
	end

	// Result register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp <= '0;
		end else begin
			rsp.data <= res;
			rsp.sat  <= sat;
		end
	end

endmodule
